// File: etx_pkg.sv
`default_nettype none

package etx_pkg;

  // ##########################################################
  // link format widths
  // ##########################################################
  localparam int PW     = 104;  // mesh packet
  localparam int AW     = 32;   // address word
  localparam int DW     = 32;   // data word
  localparam int LW     = 64;   // parallel beat to io
  localparam int FW     = 8;    // frame pattern
  localparam int IDW    = 12;   // chip id, top bits of dstaddr
  localparam int DROP_W = 16;   // drop counter

  typedef logic [PW-1:0]     packet_t;
  typedef logic [AW-1:0]     addr_t;
  typedef logic [DW-1:0]     data_t;
  typedef logic [IDW-1:0]    chipid_t;
  typedef logic [LW-1:0]     lane_t;
  typedef logic [FW-1:0]     frame_t;
  typedef logic [1:0]        cfg_addr_t;
  typedef logic [DROP_W-1:0] drop_cnt_t;

  // ##########################################################
  // frame patterns
  // ##########################################################
  localparam frame_t FRAME_HEAD = 8'h3F;  // first beat, header lane
  localparam frame_t FRAME_BODY = 8'hFF;  // second beat, body lane

  // ##########################################################
  // test mode traffic
  // ##########################################################
  localparam chipid_t TEST_PEER_ID  = 12'h821;       // fixed peer chip
  localparam data_t   TEST_WR_DATA  = 32'h5555_5555;
  localparam data_t   TEST_RD_DATA  = 32'hAAAA_AAAA;  // dummy, reads carry no data
  localparam addr_t   TEST_SRC_ADDR = 32'h000F_0300;  // return address for reads

  // register map
  localparam cfg_addr_t CFG_CTRL   = 2'd0;  // bit0 tx_enable, bit1 test_mode
  localparam cfg_addr_t CFG_CHIPID = 2'd1;  // bits 11:0
  localparam cfg_addr_t CFG_DROPS  = 2'd2;  // read only, saturating

  // register port handshake
  typedef enum logic [1:0] {
    IDLE,     // waiting for req
    ACK,      // access done, ack high until req drops
    RELEASE   // ack dropped, handshake closed
  } cfg_state_t;

  // framer beat sequence
  typedef enum logic {
    TX_IDLE,  // may accept
    TX_BODY   // head beat on the wire, body next
  } tx_state_t;

endpackage

`default_nettype wire

// File: etx_cfg_if.sv
`default_nettype none

interface etx_cfg_if
  import etx_pkg::*;
();

  logic    tx_enable;  // transmit enable
  logic    test_mode;  // pattern generator drives the link
  chipid_t chip_id;    // local chip, for self-address filter
  logic    drop;       // one cycle per dropped packet

  modport regs (
    output tx_enable, test_mode, chip_id,
    input  drop
  );

  modport framer (
    input  tx_enable, test_mode, chip_id,
    output drop
  );

  modport gen (
    input test_mode
  );

endinterface

`default_nettype wire

// File: etx_cfg_regs.sv
`default_nettype none

module etx_cfg_regs
  import etx_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      cfg_req,
  input  logic      cfg_write,
  input  cfg_addr_t cfg_addr,
  input  data_t     cfg_wdata,
  output logic      cfg_ack,
  output data_t     cfg_rdata,
  etx_cfg_if.regs   cfg
);

  cfg_state_t state;
  logic       tx_enable_q;
  logic       test_mode_q;
  chipid_t    chip_id_q;
  drop_cnt_t  drops;
  logic       do_access;   // single access per request
  data_t      rd_mux;

  // ##########################################################
  // four-phase handshake
  // ##########################################################

  // req seen in IDLE, or already back in RELEASE
  assign do_access = cfg_req & (state != ACK);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state   <= IDLE;
      cfg_ack <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE, RELEASE:
        begin
          if (cfg_req)
          begin
            state   <= ACK;
            cfg_ack <= 1'b1;  // same edge as the access
          end
          else
            state <= IDLE;
        end
        ACK:
        begin
          if (!cfg_req)  // host saw ack and let go
          begin
            state   <= RELEASE;
            cfg_ack <= 1'b0;
          end
        end
        default:
        begin
          state   <= IDLE;
          cfg_ack <= 1'b0;
        end
      endcase
    end
  end

  // ##########################################################
  // registers
  // ##########################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      tx_enable_q <= 1'b0;
      test_mode_q <= 1'b0;
      chip_id_q   <= '0;
    end
    else if (do_access && cfg_write)
    begin
      case (cfg_addr)
        CFG_CTRL:
        begin
          tx_enable_q <= cfg_wdata[0];
          test_mode_q <= cfg_wdata[1];
        end
        CFG_CHIPID: chip_id_q <= cfg_wdata[IDW-1:0];
        default: ;  // drops read only, unmapped ignored
      endcase
    end
  end

  // saturating drop count
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      drops <= '0;
    else if (cfg.drop && (drops != '1))
      drops <= drops + 1'b1;
  end

  always_comb
  begin
    case (cfg_addr)
      CFG_CTRL:   rd_mux = {{(DW-2){1'b0}}, test_mode_q, tx_enable_q};
      CFG_CHIPID: rd_mux = {{(DW-IDW){1'b0}}, chip_id_q};
      CFG_DROPS:  rd_mux = {{(DW-DROP_W){1'b0}}, drops};
      default:    rd_mux = '0;  // unmapped reads zero
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (do_access && !cfg_write)
      cfg_rdata <= rd_mux;  // valid with ack
  end

  assign cfg.tx_enable = tx_enable_q;
  assign cfg.test_mode = test_mode_q;
  assign cfg.chip_id   = chip_id_q;

  // ack only answers a request the block has seen
  a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    $rose(cfg_ack) |-> $past(cfg_req));

endmodule

`default_nettype wire

// File: etx_test_gen.sv
`default_nettype none

module etx_test_gen
  import etx_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  etx_cfg_if.gen   cfg,
  input  logic     take,
  output packet_t  test_packet
);

  logic  rd_sel;  // 0 write, 1 read
  logic  pkt_write;
  data_t pkt_data;

  // ##########################################################
  // write/read alternation
  // ##########################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      rd_sel <= 1'b0;
    else if (!cfg.test_mode)
      rd_sel <= 1'b0;      // next test run starts with a write
    else if (take)
      rd_sel <= ~rd_sel;   // framer took this one
  end

  assign pkt_write = ~rd_sel;
  assign pkt_data  = rd_sel ? TEST_RD_DATA : TEST_WR_DATA;

  // 32-bit access to the peer, base of its address space
  assign test_packet = {TEST_SRC_ADDR,            // srcaddr
                        pkt_data,                 // data
                        TEST_PEER_ID, 20'h0_0000, // dstaddr
                        4'h0,                     // ctrlmode
                        2'b10,                    // datamode, 32 bit
                        pkt_write,
                        1'b1};                    // access

endmodule

`default_nettype wire

// File: etx_framer.sv
`default_nettype none

module etx_framer
  import etx_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       etx_access,
  input  packet_t    etx_packet,
  input  packet_t    test_packet,
  etx_cfg_if.framer  cfg,
  output logic       take,
  output logic       etx_io_wait,
  output frame_t     tx_frame_par,
  output lane_t      tx_data_par
);

  tx_state_t  state;
  packet_t    pkt;
  logic       access_in;
  logic       pkt_access;
  logic       pkt_write;
  logic [1:0] pkt_datamode;
  logic [3:0] pkt_ctrlmode;
  addr_t      pkt_dstaddr;
  data_t      pkt_data;
  addr_t      pkt_srcaddr;
  logic       self_addr;
  logic       accept;
  logic       send;
  lane_t      head_lane;
  lane_t      body_q;   // held for the second beat
  logic       drop_q;

  // ##########################################################
  // source select and field split
  // ##########################################################
  assign pkt       = cfg.test_mode ? test_packet : etx_packet;
  assign access_in = cfg.test_mode | etx_access;  // generator always has a packet

  assign pkt_access   = pkt[0];
  assign pkt_write    = pkt[1];
  assign pkt_datamode = pkt[3:2];
  assign pkt_ctrlmode = pkt[7:4];
  assign pkt_dstaddr  = pkt[39:8];
  assign pkt_data     = pkt[71:40];
  assign pkt_srcaddr  = pkt[103:72];

  // packet to ourselves never goes on the link
  assign self_addr = (pkt_dstaddr[AW-1:AW-IDW] == cfg.chip_id);

  assign accept = access_in & (cfg.tx_enable | cfg.test_mode) & (state == TX_IDLE);
  assign send   = accept & ~self_addr;
  assign take   = accept & cfg.test_mode;

  // header beat, bytes from the bottom
  assign head_lane = {16'h0000,
                      ~pkt_write, 7'h00,                  // read flag at bit 47
                      pkt_ctrlmode, pkt_dstaddr[31:28],
                      pkt_dstaddr[27:4],
                      pkt_dstaddr[3:0], pkt_datamode, pkt_write, pkt_access};

  // ##########################################################
  // two-beat sequence
  // ##########################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state        <= TX_IDLE;
      tx_frame_par <= '0;
      tx_data_par  <= '0;
      drop_q       <= 1'b0;
    end
    else
    begin
      drop_q <= accept & self_addr;  // consumed, counted next cycle
      case (state)
        TX_IDLE:
        begin
          if (send)
          begin
            state        <= TX_BODY;
            tx_frame_par <= FRAME_HEAD;
            tx_data_par  <= head_lane;
          end
          else
          begin
            tx_frame_par <= '0;  // idle wire
            tx_data_par  <= '0;
          end
        end
        TX_BODY:
        begin
          state        <= TX_IDLE;  // accept again while body is out
          tx_frame_par <= FRAME_BODY;
          tx_data_par  <= body_q;
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (send)
      body_q <= {pkt_data, pkt_srcaddr};  // data high, srcaddr low
  end

  assign etx_io_wait = (state == TX_BODY);  // high only during head beat
  assign cfg.drop    = drop_q;

  // every head is closed by its body on the next beat
  a_head_then_body: assert property (@(posedge clk) disable iff (reset)
    (tx_frame_par == FRAME_HEAD) |=> (tx_frame_par == FRAME_BODY));

endmodule

`default_nettype wire

// File: etx_wait_sync.sv
`default_nettype none

module etx_wait_sync
(
  input  logic clk,
  input  logic reset,
  input  logic tx_rd_wait,
  input  logic tx_wr_wait,
  input  logic etx_io_wait,
  output logic etx_rd_wait,
  output logic etx_wr_wait,
  output logic etx_wait
);

  logic [1:0] meta_q;  // {wr, rd}, first stage
  logic [1:0] sync_q;  // second stage

  // ##########################################################
  // io waits, two flops each
  // ##########################################################
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      meta_q <= 2'b00;
      sync_q <= 2'b00;
    end
    else
    begin
      meta_q <= {tx_wr_wait, tx_rd_wait};
      sync_q <= meta_q;
    end
  end

  assign etx_rd_wait = sync_q[0];
  assign etx_wr_wait = sync_q[1];

  // pipeline stall, framer or io
  assign etx_wait = etx_io_wait | etx_rd_wait | etx_wr_wait;

endmodule

`default_nettype wire

// File: etx_top.sv
`default_nettype none

module etx_top
  import etx_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  // register port
  input  logic      cfg_req,
  input  logic      cfg_write,
  input  cfg_addr_t cfg_addr,
  input  data_t     cfg_wdata,
  output logic      cfg_ack,
  output data_t     cfg_rdata,
  // system side
  input  logic      etx_access,
  input  packet_t   etx_packet,
  output logic      etx_io_wait,
  output logic      etx_rd_wait,
  output logic      etx_wr_wait,
  output logic      etx_wait,
  // io side
  input  logic      tx_rd_wait,
  input  logic      tx_wr_wait,
  output frame_t    tx_frame_par,
  output lane_t     tx_data_par
);

  packet_t test_packet;
  logic    take;

  etx_cfg_if cfg_bus ();

  // ##########################################################
  // config and test source
  // ##########################################################
  etx_cfg_regs cfg_regs_i (
    .clk       (clk),
    .reset     (reset),
    .cfg_req   (cfg_req),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata),
    .cfg       (cfg_bus.regs)
  );

  etx_test_gen test_gen_i (
    .clk         (clk),
    .reset       (reset),
    .cfg         (cfg_bus.gen),
    .take        (take),
    .test_packet (test_packet)
  );

  // ##########################################################
  // framing and stall
  // ##########################################################
  etx_framer framer_i (
    .clk          (clk),
    .reset        (reset),
    .etx_access   (etx_access),
    .etx_packet   (etx_packet),
    .test_packet  (test_packet),
    .cfg          (cfg_bus.framer),
    .take         (take),
    .etx_io_wait  (etx_io_wait),
    .tx_frame_par (tx_frame_par),
    .tx_data_par  (tx_data_par)
  );

  etx_wait_sync wait_sync_i (
    .clk         (clk),
    .reset       (reset),
    .tx_rd_wait  (tx_rd_wait),
    .tx_wr_wait  (tx_wr_wait),
    .etx_io_wait (etx_io_wait),
    .etx_rd_wait (etx_rd_wait),
    .etx_wr_wait (etx_wr_wait),
    .etx_wait    (etx_wait)
  );

endmodule

`default_nettype wire

// File: etx_tb.sv
`default_nettype none

module etx_tb
  import etx_pkg::*;
();

  localparam int MAX_CYCLES = 2000;  // all six tests need about 400

  logic      clk;
  logic      reset;
  logic      cfg_req;
  logic      cfg_write;
  cfg_addr_t cfg_addr;
  data_t     cfg_wdata;
  logic      cfg_ack;
  data_t     cfg_rdata;
  logic      etx_access;
  packet_t   etx_packet;
  logic      etx_io_wait;
  logic      etx_rd_wait;
  logic      etx_wr_wait;
  logic      etx_wait;
  logic      tx_rd_wait;
  logic      tx_wr_wait;
  frame_t    tx_frame_par;
  lane_t     tx_data_par;

  int        errors = 0;
  int        checks = 0;
  int        tests = 0;
  int        cycles = 0;
  frame_t    exp_frame_q[$];  // beats still owed by the DUT
  lane_t     exp_lane_q[$];
  logic      tx_on = 1'b0;    // mirror of CTRL tx_enable
  chipid_t   chip_id_m = '0;  // mirror of CHIPID
  logic      tm_check = 1'b0; // frames come from the pattern generator
  int        tm_heads = 0;
  int        tm_bodies = 0;
  logic [1:0] rd_hist;        // io waits as sampled on the last two edges
  logic [1:0] wr_hist;

  etx_top etx_top_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ##########################################################
  // expected beats, straight from the link format
  // ##########################################################
  function automatic packet_t make_packet(input logic wr, input logic [1:0] dm,
      input logic [3:0] cm, input addr_t dst, input data_t d, input addr_t src);
    packet_t p;
    p = '0;
    p[0]      = 1'b1;  // access
    p[1]      = wr;
    p[3:2]    = dm;
    p[7:4]    = cm;
    p[39:8]   = dst;
    p[71:40]  = d;
    p[103:72] = src;
    return p;
  endfunction

  function automatic lane_t head_of(input packet_t p);
    lane_t l;
    l = '0;
    l[1:0]   = p[1:0];    // access, write
    l[3:2]   = p[3:2];    // datamode
    l[7:4]   = p[11:8];   // dstaddr 3:0
    l[31:8]  = p[35:12];  // dstaddr 27:4
    l[35:32] = p[39:36];  // dstaddr 31:28
    l[39:36] = p[7:4];    // ctrlmode
    l[47]    = ~p[1];     // read flag
    return l;
  endfunction

  function automatic lane_t body_of(input packet_t p);
    return {p[71:40], p[103:72]};  // data over srcaddr
  endfunction

  function automatic packet_t test_packet_of(input logic is_read);
    return make_packet(~is_read, 2'b10, 4'h0, {TEST_PEER_ID, 20'h0_0000},
                       is_read ? TEST_RD_DATA : TEST_WR_DATA, TEST_SRC_ADDR);
  endfunction

  // remote destination, never the local chip
  function automatic packet_t random_packet(input logic wr);
    addr_t dst;
    dst = $urandom;
    if (dst[31:20] == chip_id_m)
      dst[31] = ~dst[31];
    return make_packet(wr, 2'($urandom), 4'($urandom), dst, $urandom, $urandom);
  endfunction

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
      input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("Mismatch %s: got %0h exp %0h", name, got, exp);
    end
  endtask

  // ##########################################################
  // register port, four phase
  // ##########################################################
  task automatic reg_access(input logic wr, input cfg_addr_t a, input data_t d,
      output data_t rd);
    cfg_addr  = a;
    cfg_wdata = d;
    cfg_write = wr;
    cfg_req   = 1'b1;
    while (!cfg_ack)
      @(negedge clk);
    rd      = cfg_rdata;  // registered with ack
    cfg_req = 1'b0;
    while (cfg_ack)       // block releases ack
      @(negedge clk);
    cfg_write = 1'b0;
  endtask

  task automatic reg_write(input cfg_addr_t a, input data_t d);
    data_t unused;
    reg_access(1'b1, a, d, unused);
    if (a == CFG_CTRL)
      tx_on = d[0];
    if (a == CFG_CHIPID)
      chip_id_m = d[11:0];
  endtask

  task automatic reg_read(input cfg_addr_t a, output data_t d);
    reg_access(1'b0, a, '0, d);
  endtask

  // ##########################################################
  // system side
  // ##########################################################
  task automatic send_packet(input packet_t p);
    etx_packet = p;
    etx_access = 1'b1;
    while (etx_io_wait)  // held during the stall
      @(negedge clk);
    if (tx_on && (p[39:28] != chip_id_m))
    begin
      exp_frame_q.push_back(FRAME_HEAD);
      exp_lane_q.push_back(head_of(p));
      exp_frame_q.push_back(FRAME_BODY);
      exp_lane_q.push_back(body_of(p));
    end
    @(negedge clk);  // taken on the edge just passed
  endtask

  task automatic drain();
    etx_access = 1'b0;
    repeat (4) @(negedge clk);
    checks++;
    assert (exp_frame_q.size() == 0)
    else report_failure($sformatf("%0d expected beats never appeared", exp_frame_q.size()));
  endtask

  task automatic finish_test(input string name, input int err0);
    tests++;
    $display("test %0d %s: %s, %0d errors", tests, name,
             (errors == err0) ? "passed" : "failed", errors - err0);
  endtask

  task automatic check_test_beat();
    if (tx_frame_par == FRAME_HEAD)
    begin
      check_value("tx_data_par", tx_data_par, head_of(test_packet_of(tm_heads[0])));
      tm_heads++;
    end
    else
    begin
      check_value("tx_frame_par", tx_frame_par, FRAME_BODY);
      check_value("tx_data_par", tx_data_par, body_of(test_packet_of(tm_bodies[0])));
      tm_bodies++;
    end
  endtask

  // ##########################################################
  // monitors
  // ##########################################################
  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rd_hist <= '0;
      wr_hist <= '0;
    end
    else
    begin
      rd_hist <= {rd_hist[0], tx_rd_wait};
      wr_hist <= {wr_hist[0], tx_wr_wait};
    end
  end

  // outputs are all registered, stable at the falling edge
  always @(negedge clk)
  begin
    if (!reset)
    begin
      check_value("etx_rd_wait", etx_rd_wait, rd_hist[1]);  // two clocks late
      check_value("etx_wr_wait", etx_wr_wait, wr_hist[1]);
      check_value("etx_io_wait", etx_io_wait, tx_frame_par == FRAME_HEAD);
      check_value("etx_wait", etx_wait,
                  (tx_frame_par == FRAME_HEAD) | rd_hist[1] | wr_hist[1]);
      if (tx_frame_par == '0)
        check_value("tx_data_par", tx_data_par, '0);  // idle wire
      else if (tm_check)
        check_test_beat();
      else if (exp_frame_q.size() == 0)
        report_failure($sformatf("frame %0h appeared with no packet pending", tx_frame_par));
      else
      begin
        check_value("tx_frame_par", tx_frame_par, exp_frame_q.pop_front());
        check_value("tx_data_par", tx_data_par, exp_lane_q.pop_front());
      end
    end
  end

  a_ack_rise: assert property (@(posedge clk) disable iff (reset)
    $rose(cfg_ack) |-> $past(cfg_req))
    else report_failure("cfg_ack rose without a request");

  a_ack_fall: assert property (@(posedge clk) disable iff (reset)
    $fell(cfg_ack) |-> !$past(cfg_req))
    else report_failure("cfg_ack dropped while cfg_req was still high");

  initial
  begin
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles without finishing", cycles);
    $display("Test FAILED");
    $finish;
  end

  // ##########################################################
  // tests
  // ##########################################################
  initial
  begin
    int    err0;
    int    i;
    data_t rd;
    data_t drops0;
    void'($urandom(32'h9f30_b835));
    reset      = 1'b1;
    cfg_req    = 1'b0;
    cfg_write  = 1'b0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    etx_access = 1'b0;
    etx_packet = '0;
    tx_rd_wait = 1'b0;
    tx_wr_wait = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    err0 = errors;  // register port
    check_value("cfg_ack", cfg_ack, 0);
    reg_read(CFG_CTRL, rd);
    check_value("CTRL", rd, 0);
    reg_write(CFG_CHIPID, 32'h0000_05A3);
    reg_write(CFG_CTRL, 32'h1);
    reg_read(CFG_CHIPID, rd);
    check_value("CHIPID", rd, 32'h0000_05A3);
    reg_read(CFG_CTRL, rd);
    check_value("CTRL", rd, 32'h1);
    reg_write(2'd3, 32'hFFFF_FFFF);  // unmapped
    reg_read(2'd3, rd);
    check_value("cfg_rdata", rd, 0);
    reg_write(CFG_CTRL, 32'h0);
    finish_test("register port", err0);

    err0 = errors;  // disabled link stays quiet, then one write
    send_packet(random_packet(1'b1));
    drain();
    reg_write(CFG_CTRL, 32'h1);
    send_packet(random_packet(1'b1));
    drain();
    finish_test("write packet", err0);

    err0 = errors;
    for (i = 0; i < 16; i++)
      send_packet(random_packet(i[0]));  // even ones are reads
    drain();
    finish_test("back-to-back", err0);

    err0 = errors;
    reg_read(CFG_DROPS, drops0);
    for (i = 0; i < 3; i++)
    begin
      send_packet(make_packet(1'b1, 2'b10, 4'h0, {chip_id_m, 20'($urandom)},
                              $urandom, $urandom));
      send_packet(random_packet(1'b0));  // remote one in between
    end
    drain();
    reg_read(CFG_DROPS, rd);
    check_value("DROPS", rd, drops0 + 3);
    finish_test("self-address filter", err0);

    err0 = errors;
    for (i = 0; i < 24; i++)
    begin
      tx_rd_wait = 1'($urandom);
      tx_wr_wait = 1'($urandom);
      send_packet(random_packet(1'($urandom)));
    end
    tx_rd_wait = 1'b0;
    tx_wr_wait = 1'b0;
    drain();
    finish_test("wait sync", err0);

    err0 = errors;  // generator drives the link, access low
    tm_heads  = 0;
    tm_bodies = 0;
    tm_check  = 1'b1;
    reg_write(CFG_CTRL, 32'h2);
    repeat (20) @(negedge clk);
    reg_write(CFG_CTRL, 32'h0);
    repeat (4) @(negedge clk);
    tm_check = 1'b0;
    checks++;
    assert (tm_heads >= 4)
    else report_failure($sformatf("only %0d test frames seen", tm_heads));
    check_value("test bodies", tm_bodies, tm_heads);
    finish_test("test mode", err0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
etx_pkg.sv
etx_cfg_if.sv
etx_cfg_regs.sv
etx_test_gen.sv
etx_framer.sv
etx_wait_sync.sv
etx_top.sv
etx_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = etx_tb
FILELIST  = compile.f

SOURCES   = $(shell grep -v '^+' $(FILELIST))
SIM       = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
